//--- rv_core.f
+incdir+.
rv_core_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
alu.sv
execute_stage.sv
pipeline_control.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_core;

    localparam int CLK_PERIOD  = 20;
    localparam int PROG_LEN    = 200;
    localparam int IMEM_AW     = 8;
    localparam int WATCHDOG_NS = (PROG_LEN + 20) * 4 * CLK_PERIOD;
    localparam rv_core_pkg::word_t PROG_BYTES = PROG_LEN * 4;

    logic                clk = 1'b0;
    logic                reset_n = 1'b0;
    rv_core_pkg::instr_t imem_data;
    rv_core_pkg::word_t  imem_address;
    rv_core_pkg::wb_t    retire;

    rv_core_pkg::instr_t imem [2**IMEM_AW];
    rv_core_pkg::word_t  xreg [32];        // Model register state
    rv_core_pkg::word_t  fetch_q [$];      // Expected fetch addresses
    rv_core_pkg::wb_t    result_q [$];     // Expected register writes
    logic [31:0]         lcg_state = 32'd98;

    rv_core UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .imem_data    (imem_data),
        .imem_address (imem_address),
        .retire       (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction memory answers with the NOP past the program
    assign imem_data = (imem_address < PROG_BYTES) ? imem[imem_address[IMEM_AW+1:2]] : `RV_NOP;

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];          // Upper half of the state
    endfunction

    // ISA semantics by funct3
    function automatic rv_core_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                                     input rv_core_pkg::word_t a,
                                                     input rv_core_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input rv_core_pkg::word_t actual,
                              input rv_core_pkg::word_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input rv_core_pkg::reg_addr_t actual,
                             input rv_core_pkg::reg_addr_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = x%0d, expected x%0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------------------
    // Program generation and reference model
    // ----------------------------------------------------------------------
    task automatic build_program();
        logic [15:0] r;
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        logic [12:0] off;
        for (int i = 0; i < PROG_LEN; i++) begin
            r    = next_rand();
            rd   = {2'b00, r[2:0]};       // x0..x7 keeps dependencies dense
            rs1  = {2'b00, r[5:3]};
            rs2  = {2'b00, r[8:6]};
            f3   = r[11:9];
            alt  = r[12];
            r    = next_rand();
            imm  = r[11:0];
            kind = r[15:12];
            if (i < 7) begin
                imem[i] = {imm, 5'd0, `RV_F3_ADD_SUB, 5'(i + 1), `RV_OPC_OP_IMM};  // Seed x1..x7
            end else if (kind < 4'd6) begin
                imem[i] = {(alt && (f3 == `RV_F3_ADD_SUB || f3 == `RV_F3_SRL_SRA)) ?
                           `RV_F7_ALT : 7'b0, rs2, rs1, f3, rd, `RV_OPC_OP};
            end else if (kind < 4'd12) begin
                if (f3 == `RV_F3_SLL) begin
                    imm = {7'b0, imm[4:0]};
                end else if (f3 == `RV_F3_SRL_SRA) begin
                    imm = {alt ? `RV_F7_ALT : 7'b0, imm[4:0]};
                end
                imem[i] = {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
            end else begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = {2'b00, alt};        // More BEQ/BNE than BLT and friends
                end
                off = 13'(4 * (1 + imm[2:0]));   // Forward only
                imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OPC_BRANCH};
            end
        end
    endtask

    task automatic run_model();
        rv_core_pkg::word_t  pc;
        rv_core_pkg::instr_t ins;
        rv_core_pkg::word_t  a;
        rv_core_pkg::word_t  b;
        rv_core_pkg::word_t  res;
        logic                take;
        pc = `RV_RESET_PC;
        foreach (xreg[i]) xreg[i] = '0;
        while (pc < PROG_BYTES) begin
            ins  = imem[pc[IMEM_AW+1:2]];
            a    = xreg[ins[19:15]];
            b    = xreg[ins[24:20]];
            res  = '0;
            take = 1'b0;
            fetch_q.push_back(pc);
            case (ins[6:0])
                `RV_OPC_OP:     res = model_alu(ins[14:12], ins[30], a, b);
                `RV_OPC_OP_IMM: res = model_alu(ins[14:12], ins[14:12] == 3'd5 && ins[30], a,
                                                {{20{ins[31]}}, ins[31:20]});
                default: take = (ins[14:12] == `RV_F3_BEQ) ? (a == b) :
                                (ins[14:12] == `RV_F3_BNE) ? (a != b) : 1'b0;
            endcase
            if (ins[6:0] != `RV_OPC_BRANCH && ins[11:7] != 5'd0) begin
                xreg[ins[11:7]] = res;
                result_q.push_back('{reg_write: 1'b1, rd: ins[11:7], data: res});
            end
            if (take) begin
                // Three wrong-path fetches before the redirect
                for (int k = 1; k <= 3; k++) fetch_q.push_back(pc + 32'(4 * k));
                pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end else begin
                pc = pc + `RV_PC_STEP;
            end
        end
    endtask

    task automatic check_retire(input int cycle);
        rv_core_pkg::wb_t head;
        if (retire.reg_write) begin
            if (cycle < 4) begin
                $display("A result retired in cycle %0d, before any instruction could", cycle);
                abort_run();
            end else if (result_q.size() == 0) begin
                $display("x%0d retired at %0t although no result was left", retire.rd, $time);
                abort_run();
            end else begin
                head = result_q.pop_front();
                check_reg("retire.rd", retire.rd, head.rd);
                check_word("retire.data", retire.data, head.data);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        int cycle;
        build_program();
        run_model();
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        cycle = 0;
        while (fetch_q.size() != 0) begin
            check_word("imem_address", imem_address, fetch_q.pop_front());
            check_retire(cycle);
            cycle++;
            @(negedge clk);
        end
        repeat (6) begin              // Drain the last instructions
            check_retire(cycle);
            cycle++;
            @(negedge clk);
        end
        if (result_q.size() != 0) begin
            $display("Results missing: %0d register writes never retired", result_q.size());
            abort_run();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program did not complete within %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

//--- rv_core_asserts.sv
`timescale 1ns/1ps

module rv_core_asserts (
    input logic               clk,
    input logic               reset_n,
    input rv_core_pkg::word_t imem_address,
    input rv_core_pkg::wb_t   retire
);

    // Quiet retire port in reset and just after it
    no_retire_in_reset: assert property (@(posedge clk) !reset_n |-> !retire.reg_write)
        else $error("retire.reg_write high while reset_n is low");

    no_retire_after_release: assert property (@(posedge clk) $rose(reset_n) |-> !retire.reg_write)
        else $error("retire.reg_write high in the first cycle after reset");

    fetch_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        imem_address[1:0] == 2'b00)
        else $error("imem_address 0x%08h is not word aligned", imem_address);

    retire_rd_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
        retire.reg_write |-> retire.rd != '0)
        else $error("retire strobe with rd of x0");

endmodule

bind rv_core rv_core_asserts asserts_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .imem_address (imem_address),
    .retire       (retire)
);

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                 clk,
    input  logic                 reset_n,
    input  rv_core_pkg::instr_t  imem_data,
    output rv_core_pkg::word_t   imem_address,
    output rv_core_pkg::wb_t     retire
);

    rv_core_pkg::if_id_t    if_id;
    rv_core_pkg::id_ex_t    id_ex;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    rv_core_pkg::word_t     read_1;
    rv_core_pkg::word_t     read_2;
    rv_core_pkg::wb_t       exmem_wb;
    rv_core_pkg::wb_t       memwb;
    rv_core_pkg::fwd_sel_e  fwd_a;
    rv_core_pkg::fwd_sel_e  fwd_b;
    logic                   branch_taken;
    rv_core_pkg::word_t     branch_target;
    logic                   flush;

    assign retire = memwb;

    fetch_stage fetch_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush         (flush),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_address  (imem_address),
        .if_id         (if_id)
    );

    decode_stage decode_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (flush),
        .if_id   (if_id),
        .rs1     (rs1),
        .rs2     (rs2),
        .read_1  (read_1),
        .read_2  (read_2),
        .id_ex   (id_ex)
    );

    register_file regfile_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .wb      (memwb),
        .read_1  (read_1),
        .read_2  (read_2)
    );

    execute_stage execute_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush         (flush),
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .exmem_wb      (exmem_wb),
        .memwb         (memwb),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    pipeline_control control_inst (
        .id_ex_rs1    (id_ex.rs1),
        .id_ex_rs2    (id_ex.rs2),
        .exmem_wb     (exmem_wb),
        .memwb        (memwb),
        .branch_taken (branch_taken),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .flush        (flush)
    );

endmodule

//--- pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
    input  rv_core_pkg::reg_addr_t id_ex_rs1,
    input  rv_core_pkg::reg_addr_t id_ex_rs2,
    input  rv_core_pkg::wb_t       exmem_wb,
    input  rv_core_pkg::wb_t       memwb,
    input  logic                   branch_taken,
    output rv_core_pkg::fwd_sel_e  fwd_a,
    output rv_core_pkg::fwd_sel_e  fwd_b,
    output logic                   flush
);

    // Youngest producer wins
    function automatic rv_core_pkg::fwd_sel_e pick_source(
        input rv_core_pkg::reg_addr_t rs,
        input rv_core_pkg::wb_t       ex,
        input rv_core_pkg::wb_t       mw
    );
        if (ex.reg_write && ex.rd == rs) begin
            return rv_core_pkg::FWD_FROM_EXMEM;
        end else if (mw.reg_write && mw.rd == rs) begin
            return rv_core_pkg::FWD_FROM_MEMWB;
        end
        return rv_core_pkg::FWD_REG;
    endfunction

    assign fwd_a = pick_source(id_ex_rs1, exmem_wb, memwb);
    assign fwd_b = pick_source(id_ex_rs2, exmem_wb, memwb);

    assign flush = branch_taken;   // Kills IF/ID, ID/EX and EX

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    flush,
    input  rv_core_pkg::id_ex_t     id_ex,
    input  rv_core_pkg::fwd_sel_e   fwd_a,
    input  rv_core_pkg::fwd_sel_e   fwd_b,
    output rv_core_pkg::wb_t        exmem_wb,
    output rv_core_pkg::wb_t        memwb,
    output logic                    branch_taken,
    output rv_core_pkg::word_t      branch_target
);

    rv_core_pkg::word_t     op_a;
    rv_core_pkg::word_t     op_b;
    rv_core_pkg::word_t     alu_result;
    logic                   take;
    logic                   exmem_write;
    rv_core_pkg::reg_addr_t exmem_rd;
    rv_core_pkg::word_t     exmem_data;
    logic                   memwb_write;
    rv_core_pkg::reg_addr_t memwb_rd;
    rv_core_pkg::word_t     memwb_data;

    // ------------------------------------------------------------------
    // Operand forwarding
    // ------------------------------------------------------------------
    assign op_a = (fwd_a == rv_core_pkg::FWD_FROM_EXMEM) ? exmem_data :
                  (fwd_a == rv_core_pkg::FWD_FROM_MEMWB) ? memwb_data : id_ex.read_1;
    assign op_b = id_ex.use_imm ? id_ex.imm :
                  (fwd_b == rv_core_pkg::FWD_FROM_EXMEM) ? exmem_data :
                  (fwd_b == rv_core_pkg::FWD_FROM_MEMWB) ? memwb_data : id_ex.read_2;

    alu alu_inst (
        .op     (id_ex.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // Branch resolution on this cycle's compare
    always_comb begin
        case (id_ex.branch_op)
            rv_core_pkg::BR_BEQ: take = (alu_result == '0);
            rv_core_pkg::BR_BNE: take = (alu_result != '0);
            default:             take = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // EX/MEM and MEM/WB registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exmem_write  <= 1'b0;
            branch_taken <= 1'b0;
        end else if (flush) begin
            exmem_write  <= 1'b0;   // Younger instruction squashed
            branch_taken <= 1'b0;
        end else begin
            exmem_write  <= id_ex.reg_write;
            branch_taken <= take;
        end
    end

    always_ff @(posedge clk) begin
        exmem_rd      <= id_ex.rd;
        exmem_data    <= alu_result;
        branch_target <= id_ex.pc + id_ex.imm;
    end

    // Memory stage is a plain pass-through
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            memwb_write <= 1'b0;
        end else begin
            memwb_write <= exmem_write;
        end
    end

    always_ff @(posedge clk) begin
        memwb_rd   <= exmem_rd;
        memwb_data <= exmem_data;
    end

    assign exmem_wb = '{reg_write: exmem_write, rd: exmem_rd, data: exmem_data};
    assign memwb    = '{reg_write: memwb_write, rd: memwb_rd, data: memwb_data};

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_core_pkg::alu_op_e op,
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    output rv_core_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::ALU_ADD:  result = a + b;
            rv_core_pkg::ALU_SUB:  result = a - b;
            rv_core_pkg::ALU_SLL:  result = a << shamt;
            rv_core_pkg::ALU_SLT:  result = rv_core_pkg::word_t'($signed(a) < $signed(b));
            rv_core_pkg::ALU_SLTU: result = rv_core_pkg::word_t'(a < b);
            rv_core_pkg::ALU_XOR:  result = a ^ b;
            rv_core_pkg::ALU_SRL:  result = a >> shamt;
            rv_core_pkg::ALU_SRA:  result = $signed(a) >>> shamt;   // Keeps sign bit
            rv_core_pkg::ALU_OR:   result = a | b;
            default:               result = a & b;
        endcase
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::wb_t       wb,
    output rv_core_pkg::word_t     read_1,
    output rv_core_pkg::word_t     read_2
);

    // Entry 0 is never written
    rv_core_pkg::word_t regs [2**`RV_REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset_n && wb.reg_write) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle writeback is bypassed to the readers
    assign read_1 = (rs1 == '0) ? '0 :
                    (wb.reg_write && wb.rd == rs1) ? wb.data : regs[rs1];
    assign read_2 = (rs2 == '0) ? '0 :
                    (wb.reg_write && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   flush,
    input  rv_core_pkg::if_id_t    if_id,
    output rv_core_pkg::reg_addr_t rs1,
    output rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::word_t     read_1,
    input  rv_core_pkg::word_t     read_2,
    output rv_core_pkg::id_ex_t    id_ex
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     i_imm;
    rv_core_pkg::word_t     shamt_imm;
    rv_core_pkg::word_t     b_imm;
    rv_core_pkg::id_ex_t    dec;

    // ------------------------------------------------------------------
    // Field extraction and immediates
    // ------------------------------------------------------------------
    assign opcode = if_id.instr[6:0];
    assign rd     = if_id.instr[11:7];
    assign funct3 = if_id.instr[14:12];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];
    assign funct7 = if_id.instr[31:25];

    assign i_imm     = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign shamt_imm = {27'b0, if_id.instr[24:20]};
    assign b_imm     = {{20{if_id.instr[31]}}, if_id.instr[7], if_id.instr[30:25],
                        if_id.instr[11:8], 1'b0};

    // Shared by OP and OP-IMM
    function automatic rv_core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            `RV_F3_ADD_SUB: return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            `RV_F3_SLL:     return rv_core_pkg::ALU_SLL;
            `RV_F3_SLT:     return rv_core_pkg::ALU_SLT;
            `RV_F3_SLTU:    return rv_core_pkg::ALU_SLTU;
            `RV_F3_XOR:     return rv_core_pkg::ALU_XOR;
            `RV_F3_SRL_SRA: return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            `RV_F3_OR:      return rv_core_pkg::ALU_OR;
            default:        return rv_core_pkg::ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------
    always_comb begin
        dec.pc        = if_id.pc;
        dec.rs1       = rs1;
        dec.rs2       = rs2;
        dec.rd        = rd;
        dec.read_1    = read_1;
        dec.read_2    = read_2;
        dec.imm       = i_imm;
        dec.alu_op    = rv_core_pkg::ALU_ADD;
        dec.use_imm   = 1'b0;
        dec.branch_op = rv_core_pkg::BR_NONE;
        dec.reg_write = 1'b0;   // Anything unknown is a bubble

        case (opcode)
            `RV_OPC_OP: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_decode(funct3, funct7 == `RV_F7_ALT);
            end
            `RV_OPC_OP_IMM: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                // Only SRAI borrows the funct7 bits
                dec.alu_op = alu_decode(funct3,
                                        funct3 == `RV_F3_SRL_SRA && funct7 == `RV_F7_ALT);
                if (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SRL_SRA) begin
                    dec.imm = shamt_imm;
                end
            end
            `RV_OPC_BRANCH: begin
                dec.imm    = b_imm;
                dec.alu_op = rv_core_pkg::ALU_SUB;  // Zero result means equal
                if (funct3 == `RV_F3_BEQ) begin
                    dec.branch_op = rv_core_pkg::BR_BEQ;
                end else if (funct3 == `RV_F3_BNE) begin
                    dec.branch_op = rv_core_pkg::BR_BNE;
                end
            end
            default: ;
        endcase

        if (rd == '0) begin
            dec.reg_write = 1'b0;   // x0 writes vanish here
        end
    end

    // ID/EX register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            id_ex <= '0;
        end else if (flush) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   flush,
    input  rv_core_pkg::word_t     branch_target,
    input  rv_core_pkg::instr_t    imem_data,
    output rv_core_pkg::word_t     imem_address,
    output rv_core_pkg::if_id_t    if_id
);

    rv_core_pkg::word_t pc;

    assign imem_address = pc;

    // Taken branch redirects fetch one cycle after resolution
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= `RV_RESET_PC;
        end else if (flush) begin
            pc <= branch_target;
        end else begin
            pc <= pc + `RV_PC_STEP;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            if_id <= '{pc: `RV_RESET_PC, instr: `RV_NOP};
        end else begin
            if_id.pc    <= pc;
            if_id.instr <= flush ? `RV_NOP : imem_data;  // Wrong-path word dropped
        end
    end

endmodule

//--- rv_core_pkg.sv
`include "rv_core_params.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RV_XLEN-1:0]       instr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE} branch_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {FWD_REG, FWD_FROM_EXMEM, FWD_FROM_MEMWB} fwd_sel_e;

    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        word_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      read_1;
        word_t      read_2;
        word_t      imm;
        alu_op_e    alu_op;
        logic       use_imm;     // Operand b from imm
        branch_op_e branch_op;
        logic       reg_write;
    } id_ex_t;

    // Register write request
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

//--- rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Datapath widths
`define RV_XLEN        32
`define RV_REG_ADDR_W  5

// Fetch sequencing
`define RV_PC_STEP     32'd4
`define RV_RESET_PC    32'h0000_0000
`define RV_NOP         32'h0000_0013   // addi x0, x0, 0

// Major opcodes
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_BRANCH  7'b1100011

// Branch funct3
`define RV_F3_BEQ      3'b000
`define RV_F3_BNE      3'b001

// ALU funct3
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SRL_SRA  3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

`define RV_F7_ALT      7'b0100000      // Selects SUB and SRA/SRAI

`endif
